//--- logic/audio_macros.svh
// Constants assume 16-bit signed audio; changing the width needs new knee values as well
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// Sample width of every audio path
`define AO_SAMPLE_W 16

// Speaker step sits at bit 11, a base step of 2048
`define AO_SPK_STEP_LSB 11

// --------------------
// 2x curve, knee at 32767*3/7 + 1
`define AO_COMP1_A 2
`define AO_COMP1_F 4
`define AO_COMP1_X 14044
`define AO_COMP1_B 28088

// 4x curve, knee at 32767*7/31 + 1
`define AO_COMP2_A 4
`define AO_COMP2_F 8
`define AO_COMP2_X 7400
`define AO_COMP2_B 29600

// Default LED stretch, in clk_sys cycles
`define AO_LED_HOLD_CYCLES 4500000
`endif

//--- logic/audio_pkg.sv
// Audio types only; the sample width comes from the macro header and is fixed at 16 bits
`include "audio_macros.svh"

package audio_pkg;

	// --------------------
	// Sample types

	// One audio sample, two's complement
	typedef logic signed [`AO_SAMPLE_W-1:0] sample_t;

	// Speaker volume as a left shift of the base step, 0 to 3
	typedef logic [1:0] spk_volume_t;

	// --------------------
	// Compressor control

	// Gain curve selector
	// Bit 1 picks the 4x curve, so the last code acts as boost_quad
	typedef enum logic [1:0] {
		boost_none     = 2'd0,
		boost_double   = 2'd1,
		boost_quad     = 2'd2,
		boost_quad_alt = 2'd3
	} boost_t;

	// Every other code routes the compressed sum to the output
	// boost_none alone bypasses the compressor
	// Note the curve choice does not depend on bit 0

endpackage

//--- logic/panel_pkg.sv
// Request widths follow a two-disk IDE layout and one floppy controller with two lines

package panel_pkg;

	// --------------------
	// Drive counts

	// Two hard disks, three request lines each
	localparam int hdd_drives = 2;
	localparam int hdd_lines_per_drive = 3;

	// Floppy controller request lines
	localparam int fdd_lines = 2;

	// --------------------
	// Request buses

	// Drive 1 in the upper three bits, drive 0 in the lower three
	typedef logic [hdd_drives*hdd_lines_per_drive-1:0] hdd_request_t;

	typedef logic [fdd_lines-1:0] fdd_request_t;

endpackage

//--- logic/speaker_mixer.sv
// Sums wrap modulo 2^16 with no saturation; the speaker step is always positive
`include "audio_macros.svh"

module speaker_mixer (
	input  logic                   clk_sys,
	input  logic                   cpu_reset,
	input  audio_pkg::sample_t     sb_sample_l,
	input  audio_pkg::sample_t     sb_sample_r,
	input  logic                   speaker_out,
	input  audio_pkg::spk_volume_t speaker_volume,
	output audio_pkg::sample_t     mix_l,
	output audio_pkg::sample_t     mix_r
);

	// Field between the sign bit and the step LSB
	localparam int step_field_w = `AO_SAMPLE_W - `AO_SPK_STEP_LSB - 1;

	logic [step_field_w-1:0] step_field;
	audio_pkg::sample_t      spk_step;
	audio_pkg::sample_t      sum_l;
	audio_pkg::sample_t      sum_r;

	// --------------------
	// Speaker contribution

	// Volume 3 moves the bit to the top of the field,
	// the sign bit stays clear
	always_comb begin
		step_field = {{(step_field_w-1){1'b0}}, speaker_out} << speaker_volume;
		spk_step = {1'b0, step_field, {`AO_SPK_STEP_LSB{1'b0}}};
	end

	// --------------------
	// Channel sums

	// Plain 16-bit add, overflow wraps
	always_comb begin
		sum_l = sb_sample_l + spk_step;
		sum_r = sb_sample_r + spk_step;
	end

	// One register stage, a new sample every clock
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			mix_l <= '0;
			mix_r <= '0;
		end else begin
			mix_l <= sum_l;
			mix_r <= sum_r;
		end
	end

endmodule

//--- logic/sample_compressor.sv
// Curves are tuned for 16-bit signed input; the plain path bypasses the register stage
`include "audio_macros.svh"

module sample_compressor (
	input  logic               clk_sys,
	input  logic               cpu_reset,
	input  audio_pkg::sample_t mix_l,
	input  audio_pkg::sample_t mix_r,
	input  audio_pkg::boost_t  boost,
	output audio_pkg::sample_t audio_l,
	output audio_pkg::sample_t audio_r
);

	localparam int sample_w = `AO_SAMPLE_W;

	// --------------------
	// Curve constants

	// 2x curve
	localparam logic [sample_w-1:0] slope_2x = `AO_COMP1_A;
	localparam logic [sample_w-1:0] div_2x = `AO_COMP1_F;
	localparam logic [sample_w-1:0] knee_2x = `AO_COMP1_X;
	localparam logic [sample_w-1:0] offset_2x = `AO_COMP1_B;

	// 4x curve
	localparam logic [sample_w-1:0] slope_4x = `AO_COMP2_A;
	localparam logic [sample_w-1:0] div_4x = `AO_COMP2_F;
	localparam logic [sample_w-1:0] knee_4x = `AO_COMP2_X;
	localparam logic [sample_w-1:0] offset_4x = `AO_COMP2_B;

	logic               use_quad;
	audio_pkg::sample_t shaped_l;
	audio_pkg::sample_t shaped_r;
	audio_pkg::sample_t cmp_l;
	audio_pkg::sample_t cmp_r;

	// --------------------
	// Gain curve on a magnitude

	// Linear gain below the knee, a gentle slope above it
	// All unsigned 16-bit, so results wrap
	function automatic logic [sample_w-1:0] apply_curve(
		input logic [sample_w-1:0] mag,
		input logic [sample_w-1:0] slope,
		input logic [sample_w-1:0] divider,
		input logic [sample_w-1:0] knee,
		input logic [sample_w-1:0] offset
	);
		logic [sample_w-1:0] result;

		if (mag < knee) begin
			result = mag * slope;
		end else begin
			result = ((mag - knee) / divider) + offset;
		end
		return result;
	endfunction

	// Sign-magnitude wrapper around the curve
	function automatic audio_pkg::sample_t compress(
		input audio_pkg::sample_t sample,
		input logic               quad
	);
		logic [sample_w-1:0] raw;
		logic [sample_w-1:0] mag;
		logic [sample_w-1:0] shaped;

		raw = sample;
		// -32768 keeps its own bit pattern here
		mag = raw[sample_w-1] ? (~raw) + 1'b1 : raw;
		if (quad) begin
			shaped = apply_curve(mag, slope_4x, div_4x, knee_4x, offset_4x);
		end else begin
			shaped = apply_curve(mag, slope_2x, div_2x, knee_2x, offset_2x);
		end
		// Restore the sign
		if (raw[sample_w-1]) begin
			shaped = ~(shaped - 1'b1);
		end
		return shaped;
	endfunction

	// --------------------
	// Compressed path

	// Bit 1 selects the 4x curve, so boost_quad_alt shares it
	assign use_quad = boost[1];

	always_comb begin
		shaped_l = compress(mix_l, use_quad);
		shaped_r = compress(mix_r, use_quad);
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			cmp_l <= '0;
			cmp_r <= '0;
		end else begin
			cmp_l <= shaped_l;
			cmp_r <= shaped_r;
		end
	end

	// --------------------
	// Output select

	// Plain sum one cycle after the inputs, compressed sum two cycles after
	assign audio_l = (boost != audio_pkg::boost_none) ? cmp_l : mix_l;
	assign audio_r = (boost != audio_pkg::boost_none) ? cmp_r : mix_r;

endmodule

//--- logic/activity_led.sv
// Hold time is counted in clk_sys cycles; the lamp falls hold_cycles+1 cycles after the last request
`include "audio_macros.svh"

module activity_led #(
	parameter logic [31:0] hold_cycles = `AO_LED_HOLD_CYCLES
) (
	input  logic clk_sys,
	input  logic cpu_reset,
	input  logic request,
	output logic lit
);

	// Cycles left before the lamp goes dark
	logic [31:0] hold_count;

	// --------------------
	// Stretch counter

	// A request reloads the counter even while it is running,
	// so a busy drive keeps the lamp on
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			hold_count <= '0;
			lit <= 1'b0;
		end else begin
			if (hold_count == '0) begin
				lit <= 1'b0;
			end else begin
				hold_count <= hold_count - 32'd1;
				lit <= 1'b1;
			end

			// Reload wins over the decrement
			if (request) begin
				hold_count <= hold_cycles;
			end
		end
	end

endmodule

//--- logic/audio_mixdown.sv
// Single clock domain; the compressed path adds one cycle, and boost is not registered
`include "audio_macros.svh"

module audio_mixdown #(
	parameter logic [31:0] hold_cycles = `AO_LED_HOLD_CYCLES
) (
	input  logic                   clk_sys,
	input  logic                   cpu_reset,

	// Sound-card samples and PC speaker
	input  audio_pkg::sample_t     sb_sample_l,
	input  audio_pkg::sample_t     sb_sample_r,
	input  logic                   speaker_out,
	input  audio_pkg::spk_volume_t speaker_volume,

	// Compressor curve select
	input  audio_pkg::boost_t      boost,

	// Drive activity requests
	input  panel_pkg::hdd_request_t hdd_request,
	input  panel_pkg::fdd_request_t fdd_request,

	output audio_pkg::sample_t     audio_l,
	output audio_pkg::sample_t     audio_r,
	output logic                   led_disk,
	output logic                   led_user
);

	audio_pkg::sample_t mix_l;
	audio_pkg::sample_t mix_r;
	logic               hdd_active;
	logic               fdd_active;

	// --------------------
	// Audio path

	speaker_mixer speaker_mixer_inst (
		.clk_sys        (clk_sys),
		.cpu_reset      (cpu_reset),
		.sb_sample_l    (sb_sample_l),
		.sb_sample_r    (sb_sample_r),
		.speaker_out    (speaker_out),
		.speaker_volume (speaker_volume),
		.mix_l          (mix_l),
		.mix_r          (mix_r)
	);

	sample_compressor sample_compressor_inst (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.mix_l     (mix_l),
		.mix_r     (mix_r),
		.boost     (boost),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

	// --------------------
	// Activity lamps

	// Any line of either hard disk lights the disk lamp
	assign hdd_active = |hdd_request;

	// Floppy activity goes to the user lamp
	assign fdd_active = |fdd_request;

	activity_led #(
		.hold_cycles (hold_cycles)
	) hdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.request   (hdd_active),
		.lit       (led_disk)
	);

	activity_led #(
		.hold_cycles (hold_cycles)
	) fdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.request   (fdd_active),
		.lit       (led_user)
	);

endmodule

//--- verification/tb_audio_mixdown.sv
// Assumes hold_cycles of 40 and 1-cycle plain, 2-cycle boosted latency; stops at first error
`include "audio_macros.svh"

module tb_audio_mixdown;

	localparam int lamp_hold = 40;
	localparam int stream_len = 300;

	// One cycle of driven audio inputs
	typedef struct packed {
		audio_pkg::boost_t boost;
		logic [1:0]        vol;
		logic              spk;
		logic [15:0]       l;
		logic [15:0]       r;
	} stim_t;

	logic                    clk_sys;
	logic                    cpu_reset;
	audio_pkg::sample_t      sb_sample_l;
	audio_pkg::sample_t      sb_sample_r;
	logic                    speaker_out;
	audio_pkg::spk_volume_t  speaker_volume;
	audio_pkg::boost_t       boost;
	panel_pkg::hdd_request_t hdd_request;
	panel_pkg::fdd_request_t fdd_request;
	audio_pkg::sample_t      audio_l;
	audio_pkg::sample_t      audio_r;
	logic                    led_disk;
	logic                    led_user;

	stim_t       history[$];
	stim_t       cur_entry;
	stim_t       prev_entry;
	stim_t       older_entry;
	logic [15:0] exp_l;
	logic [15:0] exp_r;

	audio_mixdown #(
		.hold_cycles (lamp_hold)
	) audio_mixdown_inst (
		.clk_sys        (clk_sys),
		.cpu_reset      (cpu_reset),
		.sb_sample_l    (sb_sample_l),
		.sb_sample_r    (sb_sample_r),
		.speaker_out    (speaker_out),
		.speaker_volume (speaker_volume),
		.boost          (boost),
		.hdd_request    (hdd_request),
		.fdd_request    (fdd_request),
		.audio_l        (audio_l),
		.audio_r        (audio_r),
		.led_disk       (led_disk),
		.led_user       (led_user)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// --------------------
	// Reference model

	// Speaker step, 16-bit wrap, then the soft-knee curve on the magnitude
	function automatic logic [15:0] expected_sample(
		input logic [15:0] sample,
		input logic        spk,
		input logic [1:0]  vol,
		input logic        compressed,
		input logic        quad
	);
		int unsigned step;
		int unsigned mixed;
		int unsigned mag;
		int unsigned shaped;
		int unsigned slope;
		int unsigned divider;
		int unsigned knee;
		int unsigned offset;
		logic        negative;

		step = spk ? (32'd1 << (`AO_SPK_STEP_LSB + vol)) : 32'd0;
		mixed = (sample + step) & 32'hFFFF;
		negative = mixed[15];
		mag = negative ? ((32'd65536 - mixed) & 32'hFFFF) : mixed;
		slope = quad ? `AO_COMP2_A : `AO_COMP1_A;
		divider = quad ? `AO_COMP2_F : `AO_COMP1_F;
		knee = quad ? `AO_COMP2_X : `AO_COMP1_X;
		offset = quad ? `AO_COMP2_B : `AO_COMP1_B;
		if (mag < knee) begin
			shaped = (mag * slope) & 32'hFFFF;
		end else begin
			shaped = ((mag - knee) / divider + offset) & 32'hFFFF;
		end
		// Negate back for negative inputs
		if (negative) begin
			shaped = (32'd65536 - shaped) & 32'hFFFF;
		end
		return compressed ? 16'(shaped) : 16'(mixed);
	endfunction

	// --------------------
	// Checks and stimulus helpers

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH at time %0t: %s expected 0x%04h, actual 0x%04h",
				$time, name, expected, actual);
			$display("Verification failed");
			$fatal(1, "value check stopped the run");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at time %0t: %s", $time, what);
		$display("Verification failed");
		$fatal(1, "wait limit exceeded");
	endtask

	// Knees, extremes and a few signs
	function automatic logic [15:0] corner_value(input int idx);
		logic [15:0] value;

		case (idx)
			0: value = 16'd0;
			1: value = 16'd1;
			2: value = `AO_COMP1_X - 1;
			3: value = `AO_COMP1_X;
			4: value = `AO_COMP1_X + 1;
			5: value = `AO_COMP2_X - 1;
			6: value = `AO_COMP2_X;
			7: value = `AO_COMP2_X + 1;
			8: value = 16'h7FFF;
			9: value = 16'h8000;
			10: value = 16'hFFFF;
			11: value = 16'(-(`AO_COMP1_X));
			12: value = 16'(-(`AO_COMP2_X));
			default: value = 16'd28000;
		endcase
		return value;
	endfunction

	function automatic logic [15:0] random_sample();
		logic [15:0] value;

		if ($urandom_range(0, 1) == 1) begin
			value = corner_value($urandom_range(0, 13));
		end else begin
			value = 16'($urandom);
		end
		return value;
	endfunction

	// Drives one cycle of audio and records it for the compare process
	task automatic drive_audio(input logic [15:0] l, input logic [15:0] r, input logic spk,
			input logic [1:0] vol, input audio_pkg::boost_t bst);
		stim_t entry;

		@(posedge clk_sys);
		#1;
		sb_sample_l = l;
		sb_sample_r = r;
		speaker_out = spk;
		speaker_volume = vol;
		boost = bst;
		entry.boost = bst;
		entry.vol = vol;
		entry.spk = spk;
		entry.l = l;
		entry.r = r;
		history.push_back(entry);
		if (history.size() > 3) begin
			void'(history.pop_front());
		end
	endtask

	task automatic run_stream(input audio_pkg::boost_t bst, input int cycles);
		for (int i = 0; i < cycles; i++) begin
			drive_audio(random_sample(), random_sample(), $urandom_range(0, 3) == 0,
				2'($urandom_range(0, 3)), bst);
		end
	endtask

	task automatic idle_cycle();
		drive_audio(16'($urandom), 16'($urandom), 1'($urandom), 2'($urandom),
			audio_pkg::boost_none);
	endtask

	// One cycle with a request pattern; sel 0 is the hard disk, 1 the floppy
	task automatic lamp_cycle(input int sel, input logic [5:0] req);
		idle_cycle();
		hdd_request = (sel == 0) ? req : 6'd0;
		fdd_request = (sel == 1) ? req[1:0] : 2'd0;
		#2;
		if (sel == 0) begin
			check_value("led_user", 16'd0, led_user);
		end else begin
			check_value("led_disk", 16'd0, led_disk);
		end
	endtask

	function automatic logic lamp_state(input int sel);
		return (sel == 0) ? led_disk : led_user;
	endfunction

	// Single request cycle, then the lamp must light within 2 cycles
	task automatic pulse_and_light(input int sel, input string name, inout int since);
		logic [5:0] req;

		req = (sel == 0) ? 6'd1 << $urandom_range(0, 5) : 6'd1 << $urandom_range(0, 1);
		lamp_cycle(sel, req);
		since = 0;
		while (lamp_state(sel) !== 1'b1) begin
			if (since >= 2) begin
				report_timeout({name, " did not light within 2 cycles of a request"});
			end
			lamp_cycle(sel, 6'd0);
			since++;
		end
	endtask

	task automatic hold_lit(input int sel, input string name, inout int since,
			input int stop_at);
		while (since < stop_at) begin
			lamp_cycle(sel, 6'd0);
			since++;
			check_value(name, 16'd1, lamp_state(sel));
		end
	endtask

	task automatic wait_dark(input int sel, input string name, inout int since);
		while (lamp_state(sel) !== 1'b0) begin
			if (since >= lamp_hold + 3) begin
				report_timeout({name, " stayed lit past the hold time"});
			end
			lamp_cycle(sel, 6'd0);
			since++;
		end
	endtask

	task automatic check_lamp(input int sel, input string name);
		int since;

		// Plain pulse
		pulse_and_light(sel, name, since);
		hold_lit(sel, name, since, lamp_hold - 2);
		wait_dark(sel, name, since);
		// A second pulse while lit restarts the hold
		pulse_and_light(sel, name, since);
		hold_lit(sel, name, since, 20);
		pulse_and_light(sel, name, since);
		hold_lit(sel, name, since, lamp_hold - 2);
		wait_dark(sel, name, since);
	endtask

	// --------------------
	// Compare process

	// Plain sum from the previous cycle, compressed sum from two cycles back
	always begin
		@(posedge clk_sys);
		#3;
		if (history.size() >= 3) begin
			cur_entry = history[history.size() - 1];
			prev_entry = history[history.size() - 2];
			older_entry = history[history.size() - 3];
			if (cur_entry.boost == audio_pkg::boost_none) begin
				exp_l = expected_sample(prev_entry.l, prev_entry.spk, prev_entry.vol,
					1'b0, 1'b0);
				exp_r = expected_sample(prev_entry.r, prev_entry.spk, prev_entry.vol,
					1'b0, 1'b0);
			end else begin
				// Curve follows the boost that was present while the mix was held
				exp_l = expected_sample(older_entry.l, older_entry.spk, older_entry.vol, 1'b1,
					prev_entry.boost[1]);
				exp_r = expected_sample(older_entry.r, older_entry.spk, older_entry.vol, 1'b1,
					prev_entry.boost[1]);
			end
			check_value("audio_l", exp_l, audio_l);
			check_value("audio_r", exp_r, audio_r);
		end
	end

	// --------------------
	// Main sequence

	initial begin
		cpu_reset = 1'b1;
		sb_sample_l = '0;
		sb_sample_r = '0;
		speaker_out = 1'b0;
		speaker_volume = '0;
		boost = audio_pkg::boost_none;
		hdd_request = '0;
		fdd_request = '0;
		void'($urandom(42215));

		repeat (3) @(posedge clk_sys);
		#1;
		cpu_reset = 1'b0;
		check_value("audio_l", 16'd0, audio_l);
		check_value("audio_r", 16'd0, audio_r);
		check_value("led_disk", 16'd0, led_disk);
		check_value("led_user", 16'd0, led_user);

		run_stream(audio_pkg::boost_none, stream_len);

		// Corner sweep without the speaker, then random streams per curve
		for (int idx = 0; idx < 14; idx++) begin
			drive_audio(corner_value(idx), corner_value(13 - idx), 1'b0, 2'd0,
				audio_pkg::boost_double);
		end
		run_stream(audio_pkg::boost_double, stream_len);
		for (int idx = 0; idx < 14; idx++) begin
			drive_audio(corner_value(idx), corner_value(13 - idx), 1'b0, 2'd0,
				audio_pkg::boost_quad);
		end
		run_stream(audio_pkg::boost_quad, stream_len);
		run_stream(audio_pkg::boost_quad_alt, stream_len);

		// Boost changes every few cycles
		for (int i = 0; i < 80; i++) begin
			run_stream(audio_pkg::boost_t'($urandom_range(0, 3)), $urandom_range(1, 5));
		end

		check_lamp(0, "led_disk");
		check_lamp(1, "led_user");

		idle_cycle();
		#3;
		$display("Verification passed");
		$finish;
	end

endmodule

//--- audio_mixdown.f
+incdir+logic
logic/audio_pkg.sv
logic/panel_pkg.sv
logic/speaker_mixer.sv
logic/sample_compressor.sv
logic/activity_led.sv
logic/audio_mixdown.sv
verification/tb_audio_mixdown.sv

//--- Bender.yml
package:
  name: audio_mixdown

sources:
  - include_dirs:
      - logic
    files:
      - logic/audio_pkg.sv
      - logic/panel_pkg.sv
      - logic/speaker_mixer.sv
      - logic/sample_compressor.sv
      - logic/activity_led.sv
      - logic/audio_mixdown.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_audio_mixdown.sv
